/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tbRvExec
FLIST     ?= flist.f
LOG       ?= sim.log
OBJDIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* flist.f */
+incdir+.
rvIsaPkg.sv
rvCorePkg.sv
regReadIf.sv
pipeStage.sv
rvDecode.sv
rvExecute.sv
rvResult.sv
rvExecTop.sv
rvExec_asserts.sv
tbRvExec.sv

/* pipeStage.sv */
// Valid/ready holding register
`timescale 1ns/1ps

module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clock,
    input  logic    rstN,
    input  logic    inValid,
    output logic    inReady,
    input  payloadT inData,
    output logic    outValid,
    input  logic    outReady,
    output payloadT outData
);

    logic    validQ;
    payloadT dataQ;

    // Room when empty or when the held item leaves this cycle
    assign inReady = !validQ || outReady;

    // Occupancy follows the input whenever the slot frees up
    always_ff @(posedge clock)
    begin
        if (!rstN)
            validQ <= 1'b0;
        else if (inReady)
            validQ <= inValid;
    end

    // Payload only moves on an actual transfer
    always_ff @(posedge clock)
    begin
        if (inValid && inReady)
            dataQ <= inData;
    end

    assign outValid = validQ;
    assign outData  = dataQ;

endmodule

/* regReadIf.sv */
// Register file read port
`timescale 1ns/1ps

interface regReadIf import rvCorePkg::*; ();

    // Two source addresses out, two data words back
    regAddrT rs1Addr;
    regAddrT rs2Addr;
    wordT    rs1Data;
    wordT    rs2Data;

    // Execute side drives the addresses
    modport requester (output rs1Addr, output rs2Addr, input rs1Data, input rs2Data);

    // Register file side answers in the same cycle
    modport responder (input rs1Addr, input rs2Addr, output rs1Data, output rs2Data);

endinterface

/* rvCorePkg.sv */
// Core pipeline types
`include "rvCore_defines.svh"

package rvCorePkg;
    import rvIsaPkg::*;

    // Register index and data word
    typedef logic [$clog2(`REG_COUNT)-1:0] regAddrT;
    typedef logic [`XLEN-1:0] wordT;

    // What a finished instruction produced
    typedef enum logic [2:0] {
        RES_ALU     = 3'd0,
        RES_JUMP    = 3'd1,
        RES_BRANCH  = 3'd2,
        RES_MEMADDR = 3'd3,
        RES_ILLEGAL = 3'd4
    } resultKindT;

    // Decode output, carried to execute by the first holding stage
    typedef struct packed {
        wordT       pc;
        // Sign extended immediate of whatever format the opcode uses
        wordT       imm;
        regAddrT    rd;
        regAddrT    rs1;
        regAddrT    rs2;
        aluOpT      aluOp;
        // Operand B is the immediate
        logic       useImm;
        // Operand A is the PC
        logic       usePcA;
        logic       regWrite;
        logic       isBranch;
        logic       isJump;
        logic       isJalr;
        branchCondT branchCond;
        resultKindT kind;
    } decodedOpT;

    // Execute output, held by the result stage
    typedef struct packed {
        regAddrT    rd;
        logic       regWrite;
        wordT       value;
        wordT       nextPc;
        resultKindT kind;
    } execResultT;

endpackage

/* rvCore_defines.svh */
// RV32I core width macros
`ifndef RVCORE_DEFINES_SVH
`define RVCORE_DEFINES_SVH

// Data path and PC width
`define XLEN 32

// Integer register file size, x0 included
`define REG_COUNT 32

`endif

/* rvDecode.sv */
// RV32I instruction decoder
`include "rvCore_defines.svh"
`timescale 1ns/1ps

module rvDecode import rvIsaPkg::*, rvCorePkg::*; (
    input  logic [`XLEN-1:0] instr,
    input  wordT             pc,
    output decodedOpT        op
);

    rTypeT fields;
    logic  writes;
    wordT  immI;
    wordT  immS;
    wordT  immB;
    wordT  immU;
    wordT  immJ;

    assign fields = rTypeT'(instr);

    // Immediates of every format, all sign extended from bit 31
    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immU = {instr[31:12], 12'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Func3 to ALU op, alt picks SUB or SRA
    function automatic aluOpT aluSelect(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  aluSelect = alt ? ALU_SUB : ALU_ADD;
            3'b001:  aluSelect = ALU_SLL;
            3'b010:  aluSelect = ALU_SLT;
            3'b011:  aluSelect = ALU_SLTU;
            3'b100:  aluSelect = ALU_XOR;
            3'b101:  aluSelect = alt ? ALU_SRA : ALU_SRL;
            3'b110:  aluSelect = ALU_OR;
            default: aluSelect = ALU_AND;
        endcase
    endfunction

    always_comb
    begin
        // Defaults describe an illegal op with no side effects
        op            = '0;
        op.pc         = pc;
        op.rd         = fields.rd;
        op.rs1        = fields.rs1;
        op.rs2        = fields.rs2;
        op.aluOp      = ALU_ADD;
        op.branchCond = branchCondT'(fields.funct3);
        op.kind       = RES_ILLEGAL;
        writes        = 1'b0;
        case (opcodeT'(fields.opcode))
            OP_LUI:
            begin
                op.imm    = immU;
                op.useImm = 1'b1;
                op.aluOp  = ALU_PASSB;
                op.kind   = RES_ALU;
                writes    = 1'b1;
            end
            OP_AUIPC:
            begin
                op.imm    = immU;
                op.useImm = 1'b1;
                op.usePcA = 1'b1;
                op.kind   = RES_ALU;
                writes    = 1'b1;
            end
            OP_JAL:
            begin
                // Target is pc plus imm, link is written later
                op.imm    = immJ;
                op.useImm = 1'b1;
                op.usePcA = 1'b1;
                op.isJump = 1'b1;
                op.kind   = RES_JUMP;
                writes    = 1'b1;
            end
            OP_JALR:
            begin
                op.imm    = immI;
                op.useImm = 1'b1;
                op.isJump = 1'b1;
                op.isJalr = 1'b1;
                op.kind   = RES_JUMP;
                writes    = 1'b1;
            end
            OP_BRANCH:
            begin
                // Compare done as rs1 minus rs2
                op.imm      = immB;
                op.aluOp    = ALU_SUB;
                op.isBranch = 1'b1;
                op.kind     = RES_BRANCH;
            end
            OP_LOAD:
            begin
                op.imm    = immI;
                op.useImm = 1'b1;
                op.kind   = RES_MEMADDR;
                writes    = 1'b1;
            end
            OP_STORE:
            begin
                op.imm    = immS;
                op.useImm = 1'b1;
                op.kind   = RES_MEMADDR;
            end
            OP_IMM:
            begin
                // Only the shift right looks at func7, shamt sits in imm[4:0]
                op.imm    = immI;
                op.useImm = 1'b1;
                op.aluOp  = aluSelect(fields.funct3,
                                      (fields.funct3 == 3'b101) && fields.funct7[5]);
                op.kind   = RES_ALU;
                writes    = 1'b1;
            end
            OP_REG:
            begin
                op.aluOp = aluSelect(fields.funct3, fields.funct7[5]);
                op.kind  = RES_ALU;
                writes   = 1'b1;
            end
            default:
            begin
                op.kind = RES_ILLEGAL;
            end
        endcase
        // x0 is never a destination
        op.regWrite = writes && (fields.rd != '0);
    end

endmodule

/* rvExecTop.sv */
// RV32I execution subsystem top
`include "rvCore_defines.svh"
`timescale 1ns/1ps

module rvExecTop import rvCorePkg::*; (
    input  logic             clock,
    input  logic             rstN,
    input  logic             instrValid,
    output logic             instrReady,
    input  logic [`XLEN-1:0] instr,
    input  logic [`XLEN-1:0] pc,
    output logic             resValid,
    input  logic             resReady,
    output regAddrT          resRd,
    output logic             resRegWrite,
    output logic [`XLEN-1:0] resValue,
    output logic [`XLEN-1:0] resNextPc,
    output resultKindT       resKind
);

    decodedOpT  decOp;
    decodedOpT  stageOp;
    logic       opValid;
    logic       opReady;
    execResultT exRes;
    logic       exValid;
    logic       exReady;
    execResultT outRes;

    regReadIf regPort ();

    rvDecode decoder (
        .instr (instr),
        .pc    (pc),
        .op    (decOp)
    );

    // Decoded op register, its ready is the instruction ready
    pipeStage #(
        .payloadT(decodedOpT)
    ) decStage (
        .clock    (clock),
        .rstN     (rstN),
        .inValid  (instrValid),
        .inReady  (instrReady),
        .inData   (decOp),
        .outValid (opValid),
        .outReady (opReady),
        .outData  (stageOp)
    );

    rvExecute execStage (
        .clock    (clock),
        .rstN     (rstN),
        .opValid  (opValid),
        .opReady  (opReady),
        .op       (stageOp),
        .regRead  (regPort),
        .resValid (exValid),
        .resReady (exReady),
        .res      (exRes)
    );

    rvResult resultStage (
        .clock    (clock),
        .rstN     (rstN),
        .inValid  (exValid),
        .inReady  (exReady),
        .in       (exRes),
        .regRead  (regPort),
        .resValid (resValid),
        .resReady (resReady),
        .res      (outRes)
    );

    // Result struct onto flat ports
    assign resRd       = outRes.rd;
    assign resRegWrite = outRes.regWrite;
    assign resValue    = outRes.value;
    assign resNextPc   = outRes.nextPc;
    assign resKind     = outRes.kind;

endmodule

/* rvExec_asserts.sv */
// Result handshake assertions
`include "rvCore_defines.svh"
`timescale 1ns/1ps

module rvExec_asserts import rvCorePkg::*; (
    input logic             clock,
    input logic             rstN,
    input logic             resValid,
    input logic             resReady,
    input regAddrT          resRd,
    input logic             resRegWrite,
    input logic [`XLEN-1:0] resValue,
    input logic [`XLEN-1:0] resNextPc,
    input resultKindT       resKind
);

    // Stalled result keeps its valid and every data field
    assert property (@(posedge clock) disable iff (!rstN)
        resValid && !resReady |=> resValid
            && $stable({resRd, resRegWrite, resValue, resNextPc, resKind}))
        else $error("stalled result changed before it was taken");

    // Synchronous reset empties the result stage
    assert property (@(posedge clock) !rstN |=> !resValid)
        else $error("result valid seen right after reset");

    // x0 is never a destination of a committed result
    assert property (@(posedge clock) disable iff (!rstN)
        resValid && resReady && resRegWrite |-> resRd != '0)
        else $error("accepted result writes register zero");

endmodule

bind rvExecTop rvExec_asserts resultChecks (
    .clock       (clock),
    .rstN        (rstN),
    .resValid    (resValid),
    .resReady    (resReady),
    .resRd       (resRd),
    .resRegWrite (resRegWrite),
    .resValue    (resValue),
    .resNextPc   (resNextPc),
    .resKind     (resKind)
);

/* rvExec_input.txt */
# instr pc rd regWrite value nextPc kind (all hex)
# kind 0 ALU, 1 JUMP, 2 BRANCH, 3 MEMADDR, 4 ILLEGAL
123450B7 00000100 01 1 12345000 00000104 0
00001117 00000104 02 1 00001104 00000108 0
FFB00193 00000108 03 1 FFFFFFFB 0000010C 0
67808213 0000010C 04 1 12345678 00000110 0
00421293 00000110 05 1 23456780 00000114 0
4011D313 00000114 06 1 FFFFFFFD 00000118 0
01C1D393 00000118 07 1 0000000F 0000011C 0
0001A413 0000011C 08 1 00000001 00000120 0
0011B493 00000120 09 1 00000000 00000124 0
0FF24513 00000124 0A 1 12345687 00000128 0
005505B3 00000128 0B 1 3579BE07 0000012C 0
40458633 0000012C 0C 1 2345678F 00000130 0
00B646B3 00000130 0D 1 163CD988 00000134 0
00D1A733 00000134 0E 1 00000001 00000138 0
00D1B7B3 00000138 0F 1 00000000 0000013C 0
40E1D833 0000013C 10 1 FFFFFFFD 00000140 0
001878B3 00000140 11 1 12345000 00000144 0
00870863 00000144 00 0 00000000 00000154 2
00871863 00000148 00 0 00000000 0000014C 2
00E1C863 0000014C 00 0 00000000 0000015C 2
00E1D863 00000150 00 0 00000000 00000154 2
00E1E863 00000154 00 0 00000000 00000158 2
00E1F863 00000158 00 0 00000000 00000168 2
1000096F 0000015C 12 1 00000160 0000025C 1
003089E7 00000160 13 1 00000164 12345002 1
FFC22A03 00000164 14 1 12345674 00000168 3
00522423 00000168 00 0 12345680 0000016C 3
0000000F 0000016C 00 0 00000000 00000170 4
00508013 00000170 00 0 12345005 00000174 0
00D00AB3 00000174 15 1 163CD988 00000178 0

/* rvExecute.sv */
// Execute stage with ALU and next PC
`include "rvCore_defines.svh"
`timescale 1ns/1ps

module rvExecute import rvIsaPkg::*, rvCorePkg::*; (
    input  logic       clock,
    input  logic       rstN,
    input  logic       opValid,
    output logic       opReady,
    input  decodedOpT  op,
    regReadIf.requester regRead,
    output logic       resValid,
    input  logic       resReady,
    output execResultT res
);

    wordT       rs1Val;
    wordT       rs2Val;
    wordT       opA;
    wordT       opB;
    wordT       aluResult;
    wordT       pcPlus4;
    wordT       pcTarget;
    logic [4:0] shamt;
    logic       taken;

    // Purely combinational, the handshake passes straight through
    assign resValid = opValid;
    assign opReady  = resReady;

    // Source registers, bypass is handled by the result stage
    assign regRead.rs1Addr = op.rs1;
    assign regRead.rs2Addr = op.rs2;
    assign rs1Val = regRead.rs1Data;
    assign rs2Val = regRead.rs2Data;

    // Operand muxes
    assign opA   = op.usePcA ? op.pc : rs1Val;
    assign opB   = op.useImm ? op.imm : rs2Val;
    assign shamt = opB[4:0];

    always_comb
    begin
        case (op.aluOp)
            ALU_ADD:   aluResult = opA + opB;
            ALU_SUB:   aluResult = opA - opB;
            ALU_SLL:   aluResult = opA << shamt;
            ALU_SLT:   aluResult = wordT'($signed(opA) < $signed(opB));
            ALU_SLTU:  aluResult = wordT'(opA < opB);
            ALU_XOR:   aluResult = opA ^ opB;
            ALU_SRL:   aluResult = opA >> shamt;
            ALU_SRA:   aluResult = wordT'($signed(opA) >>> shamt);
            ALU_OR:    aluResult = opA | opB;
            ALU_AND:   aluResult = opA & opB;
            ALU_PASSB: aluResult = opB;
            default:   aluResult = '0;
        endcase
    end

    // Branch test, equality from the SUB result
    always_comb
    begin
        case (op.branchCond)
            BR_EQ:   taken = (aluResult == '0);
            BR_NE:   taken = (aluResult != '0);
            BR_LT:   taken = $signed(rs1Val) < $signed(rs2Val);
            BR_GE:   taken = $signed(rs1Val) >= $signed(rs2Val);
            BR_LTU:  taken = rs1Val < rs2Val;
            BR_GEU:  taken = rs1Val >= rs2Val;
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4  = op.pc + `XLEN'd4;
    assign pcTarget = op.pc + op.imm;

    always_comb
    begin
        res          = '0;
        res.rd       = op.rd;
        res.regWrite = op.regWrite;
        res.kind     = op.kind;
        // JALR target is rs1 plus imm from the ALU, low bit dropped
        if (op.isJalr)
            res.nextPc = {aluResult[`XLEN-1:1], 1'b0};
        else if (op.isJump || (op.isBranch && taken))
            res.nextPc = pcTarget;
        else
            res.nextPc = pcPlus4;
        // Jumps link, branches and illegal ops carry no value
        if (op.isJump)
            res.value = pcPlus4;
        else if (op.isBranch || (op.kind == RES_ILLEGAL))
            res.value = '0;
        else
            res.value = aluResult;
    end

endmodule

/* rvIsaPkg.sv */
// RV32I instruction set types
package rvIsaPkg;

    // Major opcodes handled by the decoder
    // Anything else decodes as illegal
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcodeT;

    // R-type field layout, also used to slice the other formats
    // Opcode kept raw so unknown values survive the slice
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    // ALU operations
    // PASSB forwards the second operand, used by LUI
    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_SLL   = 4'd2,
        ALU_SLT   = 4'd3,
        ALU_SLTU  = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_OR    = 4'd8,
        ALU_AND   = 4'd9,
        ALU_PASSB = 4'd10
    } aluOpT;

    // Branch tests, encoded exactly as func3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } branchCondT;

endpackage

/* rvResult.sv */
// Result stage and register file
`include "rvCore_defines.svh"
`timescale 1ns/1ps

module rvResult import rvCorePkg::*; (
    input  logic       clock,
    input  logic       rstN,
    input  logic       inValid,
    output logic       inReady,
    input  execResultT in,
    regReadIf.responder regRead,
    output logic       resValid,
    input  logic       resReady,
    output execResultT res
);

    wordT regFile [`REG_COUNT];
    logic writeEn;

    // Finished result waits here until the outside takes it
    pipeStage #(
        .payloadT(execResultT)
    ) holdStage (
        .clock    (clock),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (in),
        .outValid (resValid),
        .outReady (resReady),
        .outData  (res)
    );

    // Commit happens on the same edge as the output transfer
    assign writeEn = resValid && resReady && res.regWrite && (res.rd != '0);

    always_ff @(posedge clock)
    begin
        if (writeEn)
            regFile[res.rd] <= res.value;
    end

    // One read port, x0 first, then the held result, then the array
    function automatic wordT readReg(input regAddrT addr);
        if (addr == '0)
            readReg = '0;
        else if (resValid && res.regWrite && (res.rd == addr))
            readReg = res.value;
        else
            readReg = regFile[addr];
    endfunction

    assign regRead.rs1Data = readReg(regRead.rs1Addr);
    assign regRead.rs2Data = readReg(regRead.rs2Addr);

endmodule

/* tbRvExec.sv */
// RV32I execution subsystem testbench
`include "rvCore_defines.svh"
`timescale 1ns/1ps

module tbRvExec import rvCorePkg::*; ();

    localparam int TIMEOUT      = 200;
    // Vectors sent with resReady held high, latency checked on these
    localparam int LATENCY_VECS = 15;

    typedef struct {
        int         index;
        wordT       instr;
        wordT       pc;
        regAddrT    rd;
        logic       regWrite;
        wordT       value;
        wordT       nextPc;
        resultKindT kind;
        int         acceptCycle;
        logic       timed;
    } vecT;

    logic             clock;
    logic             rstN;
    logic             instrValid;
    logic             instrReady;
    logic [`XLEN-1:0] instr;
    logic [`XLEN-1:0] pc;
    logic             resValid;
    logic             resReady;
    regAddrT          resRd;
    logic             resRegWrite;
    logic [`XLEN-1:0] resValue;
    logic [`XLEN-1:0] resNextPc;
    resultKindT       resKind;

    vecT  vectors[$];
    vecT  expected[$];
    int   cycle = 0;
    int   received = 0;
    logic randomReady;

    rvExecTop UUT (
        .clock       (clock),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instrReady  (instrReady),
        .instr       (instr),
        .pc          (pc),
        .resValid    (resValid),
        .resReady    (resReady),
        .resRd       (resRd),
        .resRegWrite (resRegWrite),
        .resValue    (resValue),
        .resNextPc   (resNextPc),
        .resKind     (resKind)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock)
        cycle <= cycle + 1;

    // Sink ready is held high in the first phase and random afterwards
    initial
    begin : readyDriver
        logic [31:0] r;
        void'($urandom(32'h476d7e31));
        forever
        begin
            @(posedge clock);
            r = $urandom;
            resReady <= randomReady ? r[0] : 1'b1;
        end
    end

    task automatic checkValue(input string name, input wordT exp, input wordT act);
        if (exp !== act)
        begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkRd(input string name, input regAddrT exp, input regAddrT act);
        if (exp !== act)
        begin
            $display("Error %s: expected %0d, actual %0d", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "register index mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic checkKind(input string name, input resultKindT exp, input resultKindT act);
        if (exp !== act)
        begin
            $display("Error %s: expected %s, actual %s", name, exp.name(), act.name());
            $display("TEST FAILED");
            $fatal(1, "kind mismatch");
        end
    endtask

    // Scoreboard, one expectation popped per accepted result
    always @(posedge clock)
    begin : resultMonitor
        vecT e;
        if (rstN && resValid && resReady)
        begin
            if (expected.size() == 0)
            begin
                $display("A result arrived with no instruction outstanding");
                $display("TEST FAILED");
                $fatal(1, "unexpected result");
            end
            e = expected.pop_front();
            received++;
            checkFlag($sformatf("vec%0d regWrite", e.index), e.regWrite, resRegWrite);
            // Destination only matters when a register is written
            if (e.regWrite)
                checkRd($sformatf("vec%0d rd", e.index), e.rd, resRd);
            checkValue($sformatf("vec%0d value", e.index), e.value, resValue);
            checkValue($sformatf("vec%0d nextPc", e.index), e.nextPc, resNextPc);
            checkKind($sformatf("vec%0d kind", e.index), e.kind, resKind);
            if (e.timed && (cycle != e.acceptCycle + 2))
            begin
                $display("Error vec%0d latency: expected %0d, actual %0d",
                         e.index, 2, cycle - e.acceptCycle);
                $display("TEST FAILED");
                $fatal(1, "latency mismatch");
            end
        end
    end

    // Columns are hex, lines starting with # are skipped
    task automatic loadVectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        logic [31:0] f6;
        vecT         v;
        fd = $fopen("rvExec_input.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file rvExec_input.txt");
            $display("TEST FAILED");
            $fatal(1, "no vectors");
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if ((n > 0) && (line[0] != 8'h23))
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, f5, f6);
                if (n == 7)
                begin
                    v.index       = vectors.size();
                    v.instr       = f0;
                    v.pc          = f1;
                    v.rd          = f2[4:0];
                    v.regWrite    = f3[0];
                    v.value       = f4;
                    v.nextPc      = f5;
                    v.kind        = resultKindT'(f6[2:0]);
                    v.acceptCycle = 0;
                    v.timed       = 1'b0;
                    vectors.push_back(v);
                end
            end
        end
        $fclose(fd);
    endtask

    // Holds the instruction until instrReady is seen at an edge
    task automatic sendInstr(input vecT v);
        int  waitCount;
        vecT e;
        instrValid <= 1'b1;
        instr      <= v.instr;
        pc         <= v.pc;
        waitCount = 0;
        do
        begin
            @(posedge clock);
            waitCount++;
            if (waitCount > TIMEOUT)
            begin
                $display("Instruction handshake stalled, instrReady never rose");
                $display("TEST FAILED");
                $fatal(1, "instruction timeout");
            end
        end
        while (!instrReady);
        e             = v;
        e.acceptCycle = cycle;
        e.timed       = !randomReady;
        expected.push_back(e);
    endtask

    task automatic drainResults();
        int waitCount;
        waitCount = 0;
        while (expected.size() != 0)
        begin
            @(posedge clock);
            waitCount++;
            if (waitCount > TIMEOUT)
            begin
                $display("Result handshake stalled, outstanding results never arrived");
                $display("TEST FAILED");
                $fatal(1, "result timeout");
            end
        end
    endtask

    initial
    begin
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        pc          = '0;
        resReady    = 1'b0;
        randomReady = 1'b0;
        loadVectors();
        repeat (16) @(posedge clock);
        rstN <= 1'b1;
        @(posedge clock);
        foreach (vectors[i])
        begin
            // Second phase stalls the sink at random
            if (i == LATENCY_VECS)
            begin
                instrValid <= 1'b0;
                drainResults();
                randomReady <= 1'b1;
                @(posedge clock);
            end
            sendInstr(vectors[i]);
        end
        instrValid <= 1'b0;
        drainResults();
        // Pipeline is empty now, any further result would be a duplicate
        @(negedge clock);
        if (received == 0)
        begin
            $display("No result was received because no instruction was read");
            $display("TEST FAILED");
            $fatal(1, "no results");
        end
        else if (resValid)
        begin
            $display("A result was still offered after the last expected one");
            $display("TEST FAILED");
            $fatal(1, "extra result");
        end
        else
        begin
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule
